//--- vlog.f
+incdir+.
core_pkg.sv
core_ifs.sv
inst_decoder.sv
rename_regfile.sv
alu_station.sv
reorder_buffer.sv
ooo_core_top.sv
tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --top-module tb_ooo_core -f vlog.f
./obj_dir/Vtb_ooo_core > sim.log
cat sim.log
if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

//--- tb_ooo_core.sv
`include "core_params.svh"

module tb_ooo_core;

    localparam logic [3:0] op_add  = 4'd1;
    localparam logic [3:0] op_sub  = 4'd2;
    localparam logic [3:0] op_and  = 4'd3;
    localparam logic [3:0] op_or   = 4'd4;
    localparam logic [3:0] op_xor  = 4'd5;
    localparam logic [3:0] op_addi = 4'd6;
    localparam logic [3:0] op_beq  = 4'd7;
    localparam int timeout_cycles = 4000;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic                 write;
        logic [`REG_BITS-1:0] rd;
        logic [`XLEN-1:0]     value;
        logic                 taken;
        logic [`XLEN-1:0]     target;
    } expect_t;

    logic                 clk_in;
    logic                 reset;
    logic                 run;
    logic                 inst_valid;
    logic [31:0]          inst_word;
    logic [`XLEN-1:0]     inst_pc;
    logic                 full;
    logic                 commit_valid;
    logic                 commit_write;
    logic [`REG_BITS-1:0] commit_rd;
    logic [`XLEN-1:0]     commit_value;
    logic [`XLEN-1:0]     commit_pc;
    logic                 redirect_valid;
    logic [`XLEN-1:0]     redirect_pc;

    // architectural state as it stands after every issued instruction
    logic [`XLEN-1:0] model_regs [32];
    logic [`XLEN-1:0] saved_regs [32];
    expect_t          expected_q [$];
    expect_t          front;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] beq_pc;
    int               value_errors;
    int               other_errors;
    int               cycle_count;
    logic             full_seen;
    logic             redirect_seen;

    ooo_core_top dut (
        .clk_in         (clk_in),
        .reset          (reset),
        .run            (run),
        .inst_valid     (inst_valid),
        .inst_word      (inst_word),
        .inst_pc        (inst_pc),
        .full           (full),
        .commit_valid   (commit_valid),
        .commit_write   (commit_write),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_pc      (commit_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #2 clk_in = ~clk_in;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("error: time %0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("error: time %0t %s", $time, what);
    endtask

    // commit checker samples outputs before the edge updates state
    always @(posedge clk_in) begin
        if (!reset) begin
            if (full) begin
                full_seen = 1'b1;
            end
            if (commit_valid) begin
                if (expected_q.size() == 0) begin
                    report_failure($sformatf("unexpected commit at pc %h", commit_pc));
                end else begin
                    front = expected_q.pop_front();
                    if (commit_pc !== front.pc)
                        report_mismatch("commit_pc", front.pc, commit_pc);
                    if (commit_write !== front.write)
                        report_mismatch("commit_write", 32'(front.write), 32'(commit_write));
                    if (front.write && commit_rd !== front.rd)
                        report_mismatch("commit_rd", 32'(front.rd), 32'(commit_rd));
                    if (front.write && commit_value !== front.value)
                        report_mismatch("commit_value", front.value, commit_value);
                    if (redirect_valid !== front.taken)
                        report_mismatch("redirect_valid", 32'(front.taken),
                                        32'(redirect_valid));
                    if (front.taken && redirect_valid) begin
                        if (redirect_pc !== front.target)
                            report_mismatch("redirect_pc", front.target, redirect_pc);
                        // everything younger is flushed
                        expected_q.delete();
                        redirect_seen = 1'b1;
                    end
                end
            end else if (redirect_valid) begin
                report_failure("redirect_valid high without a commit");
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            other_errors++;
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("test failed");
            $finish;
        end
    end

    // hold the instruction until accepted and update the model in order
    task automatic issue(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [12:0] imm);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] immx;
        expect_t          entry;
        @(negedge clk_in);
        inst_valid = 1'b1;
        inst_word = {op, rd, rs1, rs2, imm};
        inst_pc = next_pc;
        @(posedge clk_in);
        while (full) @(posedge clk_in);
        a = model_regs[rs1];
        b = model_regs[rs2];
        immx = {{(`XLEN-13){imm[12]}}, imm};
        entry = '0;
        entry.pc = next_pc;
        entry.rd = rd;
        entry.write = (op != op_beq) && (rd != 5'd0);
        case (op)
            op_add:  entry.value = a + b;
            op_sub:  entry.value = a - b;
            op_and:  entry.value = a & b;
            op_or:   entry.value = a | b;
            op_xor:  entry.value = a ^ b;
            op_addi: entry.value = a + immx;
            default: entry.value = '0;
        endcase
        if (op == op_beq) begin
            entry.taken = (a == b);
            entry.target = next_pc + immx;
        end
        if (entry.write) begin
            model_regs[rd] = entry.value;
        end
        expected_q.push_back(entry);
        next_pc = next_pc + 4;
    endtask

    task automatic idle();
        @(negedge clk_in);
        inst_valid = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (expected_q.size() != 0) @(posedge clk_in);
    endtask

    task automatic test_reset();
        @(negedge clk_in);
        if (full !== 1'b0) report_mismatch("full", 32'd0, 32'(full));
        if (commit_valid !== 1'b0) report_mismatch("commit_valid", 32'd0, 32'(commit_valid));
        if (redirect_valid !== 1'b0)
            report_mismatch("redirect_valid", 32'd0, 32'(redirect_valid));
    endtask

    task automatic test_independent();
        issue(op_addi, 5'd1, 5'd0, 5'd0, 13'd25);
        issue(op_addi, 5'd2, 5'd0, 5'd0, 13'h1ff0);
        issue(op_addi, 5'd3, 5'd0, 5'd0, 13'h0f3);
        issue(op_addi, 5'd4, 5'd0, 5'd0, 13'd7);
        issue(op_add, 5'd5, 5'd1, 5'd2, 13'd0);
        issue(op_sub, 5'd6, 5'd1, 5'd3, 13'd0);
        issue(op_and, 5'd7, 5'd2, 5'd3, 13'd0);
        issue(op_or, 5'd8, 5'd1, 5'd4, 13'd0);
        issue(op_xor, 5'd9, 5'd2, 5'd4, 13'd0);
        drain();
    endtask

    // each one reads the rd written just before it
    task automatic test_chain();
        issue(op_addi, 5'd10, 5'd1, 5'd0, 13'd3);
        for (int i = 0; i < 8; i++) begin
            issue((i % 3 == 2) ? op_xor : ((i % 2 == 1) ? op_sub : op_add),
                  5'(11 + i), 5'(10 + i), 5'd2, 13'd0);
        end
        drain();
    endtask

    task automatic test_backpressure_freeze();
        full_seen = 1'b0;
        for (int i = 0; i < 12; i++) begin
            issue(op_addi, 5'd20, 5'd20, 5'd0, 13'd5);
        end
        idle();
        if (!full_seen) report_failure("full never rose during the long chain");
        issue(op_addi, 5'd21, 5'd20, 5'd0, 13'd1);
        issue(op_add, 5'd22, 5'd21, 5'd20, 13'd0);
        @(negedge clk_in);
        inst_valid = 1'b0;
        run = 1'b0;
        repeat (6) begin
            @(posedge clk_in);
            if (commit_valid) report_failure("commit_valid high while run is low");
        end
        @(negedge clk_in);
        run = 1'b1;
        drain();
    endtask

    task automatic test_branches();
        issue(op_addi, 5'd10, 5'd0, 5'd0, 13'd5);
        issue(op_addi, 5'd11, 5'd0, 5'd0, 13'd5);
        issue(op_addi, 5'd12, 5'd0, 5'd0, 13'd7);
        issue(op_beq, 5'd0, 5'd10, 5'd12, 13'd40);
        issue(op_add, 5'd13, 5'd10, 5'd12, 13'd0);
        drain();
        // taken branch with two younger instructions behind it
        redirect_seen = 1'b0;
        beq_pc = next_pc;
        issue(op_beq, 5'd0, 5'd10, 5'd11, 13'd64);
        saved_regs = model_regs;
        issue(op_addi, 5'd13, 5'd0, 5'd0, 13'd99);
        issue(op_addi, 5'd10, 5'd10, 5'd0, 13'd1);
        idle();
        while (!redirect_seen) @(posedge clk_in);
        model_regs = saved_regs;
        next_pc = beq_pc + 64;
        repeat (4) @(posedge clk_in);
        issue(op_addi, 5'd13, 5'd10, 5'd0, 13'd2);
        issue(op_add, 5'd14, 5'd13, 5'd11, 13'd0);
        drain();
    endtask

    task automatic test_random();
        int waited;
        for (int i = 0; i < 60; i++) begin
            issue(4'($urandom_range(6, 1)), 5'($urandom_range(8, 1)),
                  5'($urandom_range(8, 0)), 5'($urandom_range(8, 0)), 13'($urandom));
        end
        idle();
        // bounded wait for the last commits to retire
        waited = 0;
        while (expected_q.size() != 0 && waited < 200) begin
            @(negedge clk_in);
            waited++;
        end
        if (expected_q.size() != 0) report_failure("expected commits left over at the end");
    endtask

    initial begin
        void'($urandom(32'h1cc9de94));
        clk_in = 1'b0;
        reset = 1'b1;
        run = 1'b1;
        inst_valid = 1'b0;
        inst_word = '0;
        inst_pc = '0;
        value_errors = 0;
        other_errors = 0;
        cycle_count = 0;
        full_seen = 1'b0;
        redirect_seen = 1'b0;
        next_pc = 32'h1000;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        test_reset();
        test_independent();
        test_chain();
        test_backpressure_freeze();
        test_branches();
        test_random();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- ooo_core_top.sv
`include "core_params.svh"

module ooo_core_top (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 inst_valid,
    input  logic [31:0]          inst_word,
    input  logic [`XLEN-1:0]     inst_pc,
    output logic                 full,
    output logic                 commit_valid,
    output logic                 commit_write,
    output logic [`REG_BITS-1:0] commit_rd,
    output logic [`XLEN-1:0]     commit_value,
    output logic [`XLEN-1:0]     commit_pc,
    output logic                 redirect_valid,
    output logic [`XLEN-1:0]     redirect_pc
);

    dispatch_if   disp_bus ();
    reg_lookup_if reg_bus ();
    rob_lookup_if rob_bus ();
    commit_if     cmt_bus ();

    logic               cdb_valid;
    core_pkg::rob_tag_t cdb_tag;
    logic [`XLEN-1:0]   cdb_value;
    logic               flush;

    inst_decoder u_decoder (
        .disp       (disp_bus.decoder),
        .regq       (reg_bus.decoder),
        .robq       (rob_bus.decoder),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .inst_pc    (inst_pc),
        .run        (run)
    );

    rename_regfile u_regfile (
        .clk_in (clk_in),
        .reset  (reset),
        .run    (run),
        .flush  (flush),
        .disp   (disp_bus.regfile),
        .regq   (reg_bus.regfile),
        .cmt    (cmt_bus.regfile)
    );

    alu_station u_station (
        .clk_in    (clk_in),
        .reset     (reset),
        .run       (run),
        .flush     (flush),
        .disp      (disp_bus.station),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

    reorder_buffer u_rob (
        .clk_in         (clk_in),
        .reset          (reset),
        .run            (run),
        .disp           (disp_bus.rob),
        .robq           (rob_bus.rob),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cmt            (cmt_bus.rob),
        .flush          (flush),
        .commit_pc      (commit_pc),
        .is_branch      (),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    assign full = disp_bus.rob_full || disp_bus.rs_full;

    assign commit_valid = cmt_bus.valid;
    assign commit_write = cmt_bus.writes_rd;
    assign commit_rd = cmt_bus.rd;
    assign commit_value = cmt_bus.value;

endmodule

//--- reorder_buffer.sv
`include "core_params.svh"

module reorder_buffer (
    input  logic clk_in,
    input  logic reset,
    input  logic run,
    dispatch_if.rob   disp,
    rob_lookup_if.rob robq,
    input  logic               cdb_valid,
    input  core_pkg::rob_tag_t cdb_tag,
    input  logic [`XLEN-1:0]   cdb_value,
    commit_if.rob     cmt,
    output logic             flush,
    output logic [`XLEN-1:0] commit_pc,
    output logic             is_branch,
    output logic             redirect_valid,
    output logic [`XLEN-1:0] redirect_pc
);

    localparam int DEPTH = 1 << `ROB_BITS;

    logic [DEPTH-1:0]     busy;
    logic [DEPTH-1:0]     done;
    logic [DEPTH-1:0]     writes_rd;
    core_pkg::op_e        op [DEPTH];
    logic [`REG_BITS-1:0] rd [DEPTH];
    logic [`XLEN-1:0]     pc [DEPTH];
    logic [`XLEN-1:0]     target [DEPTH];
    logic [`XLEN-1:0]     value [DEPTH];
    core_pkg::rob_tag_t   head;
    core_pkg::rob_tag_t   tail;
    logic [`ROB_BITS:0]   count;

    assign disp.tail = tail;
    // msb of count set means all 8 entries in use
    assign disp.rob_full = count[`ROB_BITS];

    // head retires as soon as its result is in
    assign cmt.valid = run && busy[head] && done[head];
    assign cmt.writes_rd = writes_rd[head];
    assign cmt.rd = rd[head];
    assign cmt.value = value[head];
    assign cmt.tag = head;

    assign commit_pc = pc[head];
    assign is_branch = (op[head] == core_pkg::op_beq);

    // predicted not-taken, so a taken beq is a mispredict
    assign redirect_valid = cmt.valid && is_branch && value[head][0];
    assign redirect_pc = target[head];
    assign flush = redirect_valid;

    // lookups also see the result on the bus this cycle
    always_comb begin
        robq.ready1 = done[robq.tag1] || (cdb_valid && cdb_tag == robq.tag1);
        robq.value1 = done[robq.tag1] ? value[robq.tag1] : cdb_value;
        robq.ready2 = done[robq.tag2] || (cdb_valid && cdb_tag == robq.tag2);
        robq.value2 = done[robq.tag2] ? value[robq.tag2] : cdb_value;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            busy <= '0;
            done <= '0;
        end else if (run) begin
            if (flush) begin
                head <= '0;
                tail <= '0;
                count <= '0;
                busy <= '0;
                done <= '0;
            end else begin
                if (cdb_valid && busy[cdb_tag]) begin
                    done[cdb_tag] <= 1'b1;
                    value[cdb_tag] <= cdb_value;
                end
                if (disp.valid) begin
                    busy[tail] <= 1'b1;
                    done[tail] <= 1'b0;
                    op[tail] <= disp.op;
                    rd[tail] <= disp.rd;
                    writes_rd[tail] <= disp.writes_rd;
                    pc[tail] <= disp.pc;
                    target[tail] <= disp.target;
                    tail <= tail + 1'b1;
                end
                if (cmt.valid) begin
                    busy[head] <= 1'b0;
                    done[head] <= 1'b0;
                    head <= head + 1'b1;
                end
                case ({disp.valid, cmt.valid})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule

//--- alu_station.sv
`include "core_params.svh"

module alu_station (
    input  logic clk_in,
    input  logic reset,
    input  logic run,
    input  logic flush,
    dispatch_if.station disp,
    output logic               cdb_valid,
    output core_pkg::rob_tag_t cdb_tag,
    output logic [`XLEN-1:0]   cdb_value
);

    localparam int IDX_BITS = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] valid;
    core_pkg::op_e        op [`RS_DEPTH];
    core_pkg::rob_tag_t   dest [`RS_DEPTH];
    core_pkg::operand_t   src1 [`RS_DEPTH];
    core_pkg::operand_t   src2 [`RS_DEPTH];
    logic                 free_found;
    logic                 issue_found;
    logic [IDX_BITS-1:0]  free_idx;
    logic [IDX_BITS-1:0]  issue_idx;

    function automatic logic [`XLEN-1:0] alu(input core_pkg::op_e f_op,
                                            input logic [`XLEN-1:0] a,
                                            input logic [`XLEN-1:0] b);
        case (f_op)
            core_pkg::op_add:  return a + b;
            core_pkg::op_sub:  return a - b;
            core_pkg::op_and:  return a & b;
            core_pkg::op_or:   return a | b;
            core_pkg::op_xor:  return a ^ b;
            // b holds the sign-extended immediate
            core_pkg::op_addi: return a + b;
            // taken flag for the rob
            core_pkg::op_beq:  return (a == b) ? `XLEN'd1 : `XLEN'd0;
            default:           return '0;
        endcase
    endfunction

    // scan downwards so the lowest index wins
    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        issue_found = 1'b0;
        issue_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_found = 1'b1;
                free_idx = IDX_BITS'(i);
            end
            if (valid[i] && src1[i].ready && src2[i].ready) begin
                issue_found = 1'b1;
                issue_idx = IDX_BITS'(i);
            end
        end
    end

    assign disp.rs_full = !free_found;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid <= '0;
            cdb_valid <= 1'b0;
        end else if (run) begin
            if (flush) begin
                valid <= '0;
                cdb_valid <= 1'b0;
            end else begin
                // registered alu result goes out on the bus
                cdb_valid <= issue_found;
                if (issue_found) begin
                    valid[issue_idx] <= 1'b0;
                    cdb_tag <= dest[issue_idx];
                    cdb_value <= alu(op[issue_idx], src1[issue_idx].value,
                                     src2[issue_idx].value);
                end
                // wake up operands waiting on the bus tag
                for (int i = 0; i < `RS_DEPTH; i++) begin
                    if (cdb_valid && !src1[i].ready && src1[i].tag == cdb_tag) begin
                        src1[i].ready <= 1'b1;
                        src1[i].value <= cdb_value;
                    end
                    if (cdb_valid && !src2[i].ready && src2[i].tag == cdb_tag) begin
                        src2[i].ready <= 1'b1;
                        src2[i].value <= cdb_value;
                    end
                end
                if (disp.valid) begin
                    valid[free_idx] <= 1'b1;
                    op[free_idx] <= disp.op;
                    dest[free_idx] <= disp.tail;
                    src1[free_idx] <= disp.src1;
                    src2[free_idx] <= disp.src2;
                end
            end
        end
    end

endmodule

//--- rename_regfile.sv
`include "core_params.svh"

module rename_regfile (
    input  logic clk_in,
    input  logic reset,
    input  logic run,
    input  logic flush,
    dispatch_if.regfile   disp,
    reg_lookup_if.regfile regq,
    commit_if.regfile     cmt
);

    localparam int NUM_REGS = 1 << `REG_BITS;

    logic [`XLEN-1:0]   regs [NUM_REGS];
    logic [NUM_REGS-1:0] busy;
    core_pkg::rob_tag_t tags [NUM_REGS];
    logic               rename_en;
    logic               write_en;
    logic               keep_busy;

    assign rename_en = disp.valid && disp.writes_rd;
    assign write_en = cmt.valid && cmt.writes_rd && (cmt.rd != '0);

    // a newer rename of the same register outlives this commit
    assign keep_busy = (tags[cmt.rd] != cmt.tag) || (rename_en && disp.rd == cmt.rd);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (run) begin
            if (write_en) begin
                regs[cmt.rd] <= cmt.value;
                if (!keep_busy) begin
                    busy[cmt.rd] <= 1'b0;
                end
            end
            // flush drops every rename, committed values stay
            if (flush) begin
                busy <= '0;
            end else if (rename_en) begin
                busy[disp.rd] <= 1'b1;
                tags[disp.rd] <= disp.tail;
            end
        end
    end

    // x0 reads zero and never waits
    always_comb begin
        regq.busy1 = (regq.rs1 != '0) && busy[regq.rs1];
        regq.tag1 = tags[regq.rs1];
        regq.value1 = (regq.rs1 == '0) ? '0 : regs[regq.rs1];
        regq.busy2 = (regq.rs2 != '0) && busy[regq.rs2];
        regq.tag2 = tags[regq.rs2];
        regq.value2 = (regq.rs2 == '0) ? '0 : regs[regq.rs2];
    end

endmodule

//--- inst_decoder.sv
`include "core_params.svh"

module inst_decoder (
    dispatch_if.decoder   disp,
    reg_lookup_if.decoder regq,
    rob_lookup_if.decoder robq,
    input  logic             inst_valid,
    input  logic [31:0]      inst_word,
    input  logic [`XLEN-1:0] inst_pc,
    input  logic             run
);

    logic [3:0]         op_field;
    logic [`XLEN-1:0]   imm;
    core_pkg::op_e      op;
    core_pkg::operand_t reg_src1;
    core_pkg::operand_t reg_src2;
    core_pkg::operand_t zero_src;
    core_pkg::operand_t imm_src;

    assign op_field = inst_word[31:28];
    assign imm = {{(`XLEN-13){inst_word[12]}}, inst_word[12:0]};

    // unused opcode values decode as nop
    assign op = (op_field <= 4'd7) ? core_pkg::op_e'(op_field) : core_pkg::op_nop;

    assign regq.rs1 = inst_word[22:18];
    assign regq.rs2 = inst_word[17:13];

    // busy registers are chased in the rob by their rename tag
    assign robq.tag1 = regq.tag1;
    assign robq.tag2 = regq.tag2;

    always_comb begin
        reg_src1.ready = !regq.busy1 || robq.ready1;
        reg_src1.tag = regq.tag1;
        reg_src1.value = regq.busy1 ? robq.value1 : regq.value1;
        reg_src2.ready = !regq.busy2 || robq.ready2;
        reg_src2.tag = regq.tag2;
        reg_src2.value = regq.busy2 ? robq.value2 : regq.value2;
    end

    assign zero_src = '{ready: 1'b1, tag: '0, value: '0};
    assign imm_src = '{ready: 1'b1, tag: '0, value: imm};

    // nop carries no sources so it never waits
    assign disp.src1 = (op == core_pkg::op_nop) ? zero_src : reg_src1;

    always_comb begin
        case (op)
            core_pkg::op_nop:  disp.src2 = zero_src;
            core_pkg::op_addi: disp.src2 = imm_src;
            default:           disp.src2 = reg_src2;
        endcase
    end

    assign disp.op = op;
    assign disp.rd = inst_word[27:23];
    assign disp.writes_rd = (op != core_pkg::op_nop) && (op != core_pkg::op_beq)
                            && (inst_word[27:23] != '0);
    assign disp.pc = inst_pc;
    assign disp.target = inst_pc + imm;

    // accept only when both rob and station have room
    assign disp.valid = inst_valid && run && !disp.rob_full && !disp.rs_full;

endmodule

//--- core_ifs.sv
`include "core_params.svh"

// decoded entry going to rob, station and regfile
interface dispatch_if;
    logic                 valid;
    core_pkg::op_e        op;
    logic [`REG_BITS-1:0] rd;
    logic                 writes_rd;
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     target;
    core_pkg::operand_t   src1;
    core_pkg::operand_t   src2;
    core_pkg::rob_tag_t   tail;
    logic                 rob_full;
    logic                 rs_full;

    modport decoder (output valid, op, rd, writes_rd, pc, target, src1, src2,
                     input rob_full, rs_full);
    modport rob (input valid, op, rd, writes_rd, pc, target, output tail, rob_full);
    modport station (input valid, op, src1, src2, tail, output rs_full);
    modport regfile (input valid, rd, writes_rd, tail);
endinterface

// source register read, combinational
interface reg_lookup_if;
    logic [`REG_BITS-1:0] rs1, rs2;
    logic                 busy1, busy2;
    core_pkg::rob_tag_t   tag1, tag2;
    logic [`XLEN-1:0]     value1, value2;

    modport decoder (output rs1, rs2, input busy1, busy2, tag1, tag2, value1, value2);
    modport regfile (input rs1, rs2, output busy1, busy2, tag1, tag2, value1, value2);
endinterface

// pending result read by tag, combinational
interface rob_lookup_if;
    core_pkg::rob_tag_t tag1, tag2;
    logic               ready1, ready2;
    logic [`XLEN-1:0]   value1, value2;

    modport decoder (output tag1, tag2, input ready1, ready2, value1, value2);
    modport rob (input tag1, tag2, output ready1, ready2, value1, value2);
endinterface

// in-order retirement into the register file
interface commit_if;
    logic                 valid;
    logic                 writes_rd;
    logic [`REG_BITS-1:0] rd;
    logic [`XLEN-1:0]     value;
    core_pkg::rob_tag_t   tag;

    modport rob (output valid, writes_rd, rd, value, tag);
    modport regfile (input valid, writes_rd, rd, value, tag);
endinterface

//--- core_pkg.sv
`include "core_params.svh"

package core_pkg;

    // opcode in bits 31:28 of the instruction word
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_beq  = 4'd7
    } op_e;

    // index of a reorder buffer entry, doubles as rename tag
    typedef logic [`ROB_BITS-1:0] rob_tag_t;

    // value is valid when ready is set, otherwise wait for tag
    typedef struct packed {
        logic             ready;
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
    } operand_t;

endpackage

//--- core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width
`define XLEN 32

// architectural register index width, 32 registers
`define REG_BITS 5

// reorder buffer index width, 8 entries
`define ROB_BITS 3

// reservation station entries
`define RS_DEPTH 4

`endif
